// ==== decodeStage.f ====
+incdir+dv
logic/decodePkg.sv
logic/instrDecoder.sv
logic/regFile.sv
logic/operandIssue.sv
logic/decodeStage.sv
dv/decodeStageTb.sv

// ==== dv/decodeStageCases.svh ====
// Columns are fetchValid, fetchStall, ir, wb.en, wb.idx, wb.data
//   followed by depStall, branchStall, issue valid, src1, src2, destValue, destIdx, branchTaken
  task automatic loadCaseTable();
    // Reset and bubbles where the held-off MOVI R5 claims nothing
    addCase(0, 0, 'h00000000, 0, 0, 'h0000, 0, 0, 0, 'h0000, 'h0000, 'h0000, 0, 0);
    addCase(1, 1, 'h06050077, 0, 0, 'h0000, 0, 0, 0, 'h0000, 'h0000, 'h0000, 0, 0);
    addCase(1, 0, 'h02650003, 0, 0, 'h0000, 0, 0, 1, 'h0000, 'h0000, 'h0000, 6, 0); // ADDI
    // Claim then load R1 and R2
    addCase(1, 0, 'h06010011, 1, 6, 'h0040, 0, 0, 1, 'h0000, 'h0000, 'h0000, 1, 0);
    addCase(1, 0, 'h06020022, 1, 1, 'h1234, 0, 0, 1, 'h0000, 'h0000, 'h0000, 2, 0);
    addCase(0, 0, 'h00000000, 1, 2, 'h00F0, 0, 0, 0, 'h0000, 'h0000, 'h0000, 0, 0);
    // ADD, ADDI, AND on loaded registers
    addCase(1, 0, 'h01410200, 0, 0, 'h0000, 0, 0, 1, 'h1234, 'h00F0, 'h00F0, 4, 0);
    addCase(1, 0, 'h02710055, 1, 4, 'h1324, 0, 0, 1, 'h1234, 'h0000, 'h0000, 7, 0);
    addCase(1, 0, 'h03810600, 1, 7, 'h1289, 0, 0, 1, 'h1234, 'h0040, 'h0040, 8, 0);
    addCase(0, 0, 'h00000000, 1, 8, 'h0000, 0, 0, 0, 'h0000, 'h0000, 'h0000, 0, 0);

    ////////////////////////////////////////////////////////////////////////////
    // RAW on R3 released by the forwarded write-back
    ////////////////////////////////////////////////////////////////////////////
    addCase(1, 0, 'h060300AB, 0, 0, 'h0000, 0, 0, 1, 'h0000, 'h0000, 'h0000, 3, 0);
    addCase(1, 0, 'h01930100, 0, 0, 'h0000, 1, 0, 0, 'h0000, 'h0000, 'h0000, 0, 0);
    addCase(1, 0, 'h01930100, 0, 0, 'h0000, 1, 0, 0, 'h0000, 'h0000, 'h0000, 0, 0);
    addCase(1, 0, 'h01930100, 1, 3, 'h00AB, 0, 0, 1, 'h00AB, 'h1234, 'h1234, 9, 0);
    addCase(0, 0, 'h00000000, 1, 9, 'h12DF, 0, 0, 0, 'h0000, 'h0000, 'h0000, 0, 0);

    // MOV and MOVI with junk in the dest field and then STW R1 to R4 base
    addCase(1, 0, 'h05FA0200, 0, 0, 'h0000, 0, 0, 1, 'h0000, 'h00F0, 'h00F0, 10, 0);
    addCase(1, 0, 'h06EB0000, 1, 10, 'h00F0, 0, 0, 1, 'h0000, 'h0000, 'h0000, 11, 0);
    addCase(1, 0, 'h11140010, 1, 11, 'h0000, 0, 0, 1, 'h1324, 'h0000, 'h1234, 1, 0);

    ////////////////////////////////////////////////////////////////////////////
    // Branches against Z, then N, then P
    ////////////////////////////////////////////////////////////////////////////
    addCase(1, 0, 'h22000000, 0, 0, 'h0000, 0, 1, 1, 'h0000, 'h0000, 'h0000, 0, 1); // BRZ
    addCase(1, 0, 'h21000000, 0, 0, 'h0000, 0, 1, 1, 'h0000, 'h0000, 'h0000, 0, 0); // BRP
    addCase(1, 0, 'h060C0000, 0, 0, 'h0000, 0, 0, 1, 'h0000, 'h0000, 'h0000, 12, 0);
    addCase(1, 0, 'h27000000, 0, 0, 'h0000, 1, 1, 0, 'h0000, 'h0000, 'h0000, 0, 0);
    addCase(1, 0, 'h27000000, 1, 12, 'h8001, 0, 1, 1, 'h0000, 'h0000, 'h0000, 0, 1);
    addCase(1, 0, 'h24000000, 0, 0, 'h0000, 0, 1, 1, 'h0000, 'h0000, 'h0000, 0, 1); // BRN
    addCase(1, 0, 'h23000000, 0, 0, 'h0000, 0, 1, 1, 'h0000, 'h0000, 'h0000, 0, 0); // BRZP
    addCase(1, 0, 'h060D0000, 0, 0, 'h0000, 0, 0, 1, 'h0000, 'h0000, 'h0000, 13, 0);
    addCase(1, 0, 'h21000000, 1, 13, 'h0042, 0, 1, 1, 'h0000, 'h0000, 'h0000, 0, 1);
    addCase(1, 0, 'h26000000, 0, 0, 'h0000, 0, 1, 1, 'h0000, 'h0000, 'h0000, 0, 0); // BRNZ
    addCase(1, 0, 'h25000000, 0, 0, 'h0000, 0, 1, 1, 'h0000, 'h0000, 'h0000, 0, 1); // BRNP
    // Branch word with valid low
    addCase(0, 0, 'h27000000, 0, 0, 'h0000, 0, 0, 0, 'h0000, 'h0000, 'h0000, 0, 0);
  endtask

// ==== dv/decodeStageTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module decodeStageTb;

  localparam time clkPeriod = 8ns;

  // One table row holds stimulus then expected values
  typedef struct packed {
    logic               fetchValid;
    logic               fetchStall;
    decodePkg::pc_t     pc;            // Filled from $urandom
    decodePkg::instr_t  ir;
    decodePkg::wbPkt_t  wb;
    logic               depStall;
    logic               branchStall;
    logic               issueValid;    // Packet one clock later
    decodePkg::word_t   src1Value;
    decodePkg::word_t   src2Value;
    decodePkg::word_t   destValue;
    decodePkg::regIdx_t destIdx;
    logic               branchTaken;
  } caseRow_t;

  logic                 I_CLOCK;
  logic                 rstN;
  decodePkg::fetchPkt_t fetch;
  logic                 fetchStall;
  decodePkg::wbPkt_t    wb;
  decodePkg::issuePkt_t issue;
  logic                 depStall;
  logic                 branchStall;

  caseRow_t caseQ[$];
  logic     tableReady;
  int       errorCount;
  int       checkCount;

  decodeStage dut (
    .I_CLOCK(I_CLOCK), .rstN(rstN), .fetch(fetch), .fetchStall(fetchStall), .wb(wb),
    .issue(issue), .depStall(depStall), .branchStall(branchStall)
  );

  task automatic addCase(input logic fv, input logic fs, input decodePkg::instr_t ir,
                         input logic wbEn, input decodePkg::regIdx_t wbIdx,
                         input decodePkg::word_t wbData, input logic dep, input logic brs,
                         input logic valid, input decodePkg::word_t s1,
                         input decodePkg::word_t s2, input decodePkg::word_t dv,
                         input decodePkg::regIdx_t di, input logic taken);
    caseQ.push_back('{fv, fs, decodePkg::pc_t'($urandom), ir, '{wbEn, wbIdx, wbData},
                      dep, brs, valid, s1, s2, dv, di, taken});
  endtask

  `include "decodeStageCases.svh"

  task automatic expectEqual(input string where, input string what,
                             input logic [15:0] got, input logic [15:0] want);
    checkCount++;
    assert (got === want)
      else begin
        errorCount++;
        $display("Error at %0t: %s %s is %h, expected %h", $time, where, what, got, want);
      end
  endtask

  // Packet produced by row i is sampled half a clock after its edge
  task automatic verifyIssue(input int i);
    string where;
    where = $sformatf("row %0d", i);
    expectEqual(where, "issue.valid", 16'(issue.valid), 16'(caseQ[i].issueValid));
    if (caseQ[i].issueValid) begin
      expectEqual(where, "issue.pc", issue.pc, caseQ[i].pc);
      expectEqual(where, "issue.opcode", 16'(issue.opcode), 16'(caseQ[i].ir[31:24]));
      expectEqual(where, "issue.imm", issue.imm, caseQ[i].ir[15:0]);   // Low half of the word
      expectEqual(where, "issue.src1Value", issue.src1Value, caseQ[i].src1Value);
      expectEqual(where, "issue.src2Value", issue.src2Value, caseQ[i].src2Value);
      expectEqual(where, "issue.destValue", issue.destValue, caseQ[i].destValue);
      expectEqual(where, "issue.destIdx", 16'(issue.destIdx), 16'(caseQ[i].destIdx));
      expectEqual(where, "issue.branchTaken", 16'(issue.branchTaken),
                  16'(caseQ[i].branchTaken));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Clock and watchdog
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    I_CLOCK = 1'b0;
    forever #(clkPeriod / 2) I_CLOCK = ~I_CLOCK;
  end

  initial begin
    wait (tableReady);
    #((caseQ.size() + 10) * clkPeriod);
    $display("Timeout: the case table did not finish within %0d clocks", caseQ.size() + 10);
    $display("Simulation failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Table loop
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    string where;
    rstN       = 1'b0;
    fetch      = '0;
    fetchStall = 1'b0;
    wb         = '0;
    errorCount = 0;
    checkCount = 0;
    tableReady = 1'b0;
    void'($urandom(32'ha4fc4494));   // Seeds the pc values
    loadCaseTable();
    tableReady = 1'b1;
    repeat (3) @(posedge I_CLOCK);
    @(negedge I_CLOCK);
    rstN = 1'b1;
    #1;
    expectEqual("reset", "issue.valid", 16'(issue.valid), 16'h0);
    expectEqual("reset", "depStall", 16'(depStall), 16'h0);
    expectEqual("reset", "branchStall", 16'(branchStall), 16'h0);

    for (int i = 0; i < caseQ.size(); i++) begin
      @(negedge I_CLOCK);
      if (i > 0) begin
        verifyIssue(i - 1);
      end
      fetch.valid = caseQ[i].fetchValid;
      fetch.pc    = caseQ[i].pc;
      fetch.ir    = caseQ[i].ir;
      fetchStall  = caseQ[i].fetchStall;
      wb          = caseQ[i].wb;
      #1;   // Stall levels settle within the low phase
      where = $sformatf("row %0d", i);
      expectEqual(where, "depStall", 16'(depStall), 16'(caseQ[i].depStall));
      expectEqual(where, "branchStall", 16'(branchStall), 16'(caseQ[i].branchStall));
    end
    @(negedge I_CLOCK);
    verifyIssue(caseQ.size() - 1);

    $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== logic/decodePkg.sv ====
`default_nettype none

package decodePkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////
  typedef logic [15:0] word_t;    // Register and data word
  typedef logic [15:0] pc_t;      // Program counter
  typedef logic [31:0] instr_t;   // Raw instruction word
  typedef logic [3:0]  regIdx_t;  // Scalar register index
  typedef logic [15:0] imm_t;     // Immediate field
  typedef logic [2:0]  cc_t;      // N/Z/P condition code

  localparam int numRegs = 16;

  // Condition code values, one bit each
  localparam cc_t CC_N = 3'b100;  // Sign bit set
  localparam cc_t CC_Z = 3'b010;  // Zero
  localparam cc_t CC_P = 3'b001;  // Positive

  // Instruction field positions
  localparam int opcodeHi = 31;
  localparam int opcodeLo = 24;
  localparam int destHi   = 23;
  localparam int destLo   = 20;
  localparam int src1Hi   = 19;
  localparam int src1Lo   = 16;
  localparam int src2Hi   = 11;
  localparam int src2Lo   = 8;
  localparam int immHi    = 15;
  localparam int immLo    = 0;

  // Branch opcodes keep their N/Z/P test mask in bits 2..0
  typedef enum logic [7:0] {
    OP_ADD   = 8'h01,
    OP_ADDI  = 8'h02,
    OP_AND   = 8'h03,
    OP_ANDI  = 8'h04,
    OP_MOV   = 8'h05,
    OP_MOVI  = 8'h06,
    OP_LDW   = 8'h10,
    OP_STW   = 8'h11,
    OP_BRP   = 8'h21,
    OP_BRZ   = 8'h22,
    OP_BRZP  = 8'h23,
    OP_BRN   = 8'h24,
    OP_BRNP  = 8'h25,
    OP_BRNZ  = 8'h26,
    OP_BRNZP = 8'h27
  } opcode_t;

  ////////////////////////////////////////////////////////////////////////////
  // Stage packets
  ////////////////////////////////////////////////////////////////////////////
  typedef struct packed {
    logic   valid;
    pc_t    pc;
    instr_t ir;
  } fetchPkt_t;

  typedef struct packed {
    logic    en;    // Single-cycle pulse
    regIdx_t idx;
    word_t   data;
  } wbPkt_t;

  typedef struct packed {
    logic    valid;
    opcode_t opcode;
    pc_t     pc;
    regIdx_t src1Idx;
    regIdx_t src2Idx;
    regIdx_t destIdx;   // Already moved for MOV/MOVI
    imm_t    imm;
    logic    usesSrc1;
    logic    usesSrc2;
    logic    writesDest;
    logic    isBranch;
    logic    isStore;   // Store data comes from destIdx
  } decoded_t;

  typedef struct packed {
    logic    valid;
    pc_t     pc;
    opcode_t opcode;
    word_t   src1Value;
    word_t   src2Value;
    word_t   destValue;   // Store data for STW
    regIdx_t destIdx;
    imm_t    imm;
    logic    branchTaken;
  } issuePkt_t;

endpackage

`default_nettype wire

// ==== logic/decodeStage.sv ====
`timescale 1ns/1ps
`default_nettype none

// Decode stage top
module decodeStage (
  input  wire                       I_CLOCK,
  input  wire                       rstN,
  input  wire decodePkg::fetchPkt_t fetch,
  input  wire                       fetchStall,
  input  wire decodePkg::wbPkt_t    wb,
  output decodePkg::issuePkt_t      issue,
  output logic                      depStall,
  output logic                      branchStall
);

  decodePkg::decoded_t dec;          // Decoder to scoreboard and issue
  decodePkg::word_t    src1Value;
  decodePkg::word_t    src2Value;
  decodePkg::word_t    storeValue;
  logic                src1Busy;
  logic                src2Busy;
  logic                anyBusy;
  decodePkg::cc_t      cc;
  logic                claim;        // Issue back to scoreboard
  decodePkg::regIdx_t  claimIdx;

  instrDecoder uDecoder (.fetch(fetch), .fetchStall(fetchStall), .dec(dec));

  regFile uRegFile (
    .I_CLOCK(I_CLOCK), .rstN(rstN), .dec(dec), .wb(wb),
    .claim(claim), .claimIdx(claimIdx),
    .src1Value(src1Value), .src2Value(src2Value), .storeValue(storeValue),
    .src1Busy(src1Busy), .src2Busy(src2Busy), .anyBusy(anyBusy), .cc(cc)
  );

  operandIssue uIssue (
    .I_CLOCK(I_CLOCK), .rstN(rstN), .dec(dec),
    .src1Value(src1Value), .src2Value(src2Value), .storeValue(storeValue),
    .src1Busy(src1Busy), .src2Busy(src2Busy), .anyBusy(anyBusy), .cc(cc),
    .claim(claim), .claimIdx(claimIdx),
    .depStall(depStall), .branchStall(branchStall), .issue(issue)
  );

endmodule

`default_nettype wire

// ==== logic/instrDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

// Pure combinational field split and classification of the fetched word
module instrDecoder (
  input  wire decodePkg::fetchPkt_t fetch,
  input  wire                       fetchStall,
  output decodePkg::decoded_t       dec
);

  decodePkg::opcode_t opcode;
  decodePkg::regIdx_t destField;
  decodePkg::regIdx_t src1Field;
  logic               movForm;   // MOV/MOVI name their target in the src1 slot

  assign opcode    = decodePkg::opcode_t'(fetch.ir[decodePkg::opcodeHi:decodePkg::opcodeLo]);
  assign destField = fetch.ir[decodePkg::destHi:decodePkg::destLo];
  assign src1Field = fetch.ir[decodePkg::src1Hi:decodePkg::src1Lo];
  assign movForm   = (opcode == decodePkg::OP_MOV) || (opcode == decodePkg::OP_MOVI);

  always_comb begin
    // Fields first, flags cleared
    dec            = '0;
    dec.valid      = fetch.valid && !fetchStall;   // Held-off word is a bubble
    dec.opcode     = opcode;
    dec.pc         = fetch.pc;
    dec.src1Idx    = src1Field;
    dec.src2Idx    = fetch.ir[decodePkg::src2Hi:decodePkg::src2Lo];
    dec.destIdx    = movForm ? src1Field : destField;
    dec.imm        = fetch.ir[decodePkg::immHi:decodePkg::immLo];

    // Operand use and write-back per opcode
    case (opcode)
      decodePkg::OP_ADD,
      decodePkg::OP_AND: begin
        dec.usesSrc1   = 1'b1;
        dec.usesSrc2   = 1'b1;
        dec.writesDest = 1'b1;
      end
      decodePkg::OP_ADDI,
      decodePkg::OP_ANDI,
      decodePkg::OP_LDW: begin
        dec.usesSrc1   = 1'b1;   // Base or first operand
        dec.writesDest = 1'b1;
      end
      decodePkg::OP_MOV: begin
        dec.usesSrc2   = 1'b1;   // Source sits in bits 11..8
        dec.writesDest = 1'b1;
      end
      decodePkg::OP_MOVI: begin
        dec.writesDest = 1'b1;   // Immediate only
      end
      decodePkg::OP_STW: begin
        dec.usesSrc1   = 1'b1;   // Address base
        dec.isStore    = 1'b1;   // Data register in the dest slot
      end
      decodePkg::OP_BRN,
      decodePkg::OP_BRZ,
      decodePkg::OP_BRP,
      decodePkg::OP_BRNZ,
      decodePkg::OP_BRNP,
      decodePkg::OP_BRZP,
      decodePkg::OP_BRNZP: begin
        dec.isBranch   = 1'b1;
      end
      default: begin
        // Unknown opcode reads nothing and writes nothing
        dec.usesSrc1   = 1'b0;
        dec.writesDest = 1'b0;
      end
    endcase

    // A branch never claims a register
    assert final (!(dec.isBranch && dec.writesDest))
      else $error("Branch opcode %h decoded with a destination write", opcode);
  end

endmodule

`default_nettype wire

// ==== logic/operandIssue.sv ====
`timescale 1ns/1ps
`default_nettype none

// Stall decision, branch resolution and the registered issue packet
module operandIssue (
  input  wire                      I_CLOCK,
  input  wire                      rstN,
  input  wire decodePkg::decoded_t dec,
  input  wire decodePkg::word_t    src1Value,
  input  wire decodePkg::word_t    src2Value,
  input  wire decodePkg::word_t    storeValue,
  input  wire                      src1Busy,
  input  wire                      src2Busy,
  input  wire                      anyBusy,
  input  wire decodePkg::cc_t      cc,
  output logic                     claim,
  output decodePkg::regIdx_t       claimIdx,
  output logic                     depStall,
  output logic                     branchStall,
  output decodePkg::issuePkt_t     issue
);

  logic src1Stall;
  logic src2Stall;
  logic brStall;       // Branch waits for a quiet scoreboard
  logic accept;        // Instruction leaves decode this cycle
  logic branchTaken;

  ////////////////////////////////////////////////////////////////////////////
  // Hazards
  ////////////////////////////////////////////////////////////////////////////
  assign src1Stall = dec.usesSrc1 & src1Busy;
  assign src2Stall = (dec.usesSrc2 | dec.isStore) & src2Busy;   // STW data reg too
  assign brStall   = dec.isBranch & anyBusy;

  assign depStall    = dec.valid & (src1Stall | src2Stall | brStall);
  assign branchStall = dec.valid & dec.isBranch;
  assign accept      = dec.valid & ~depStall;

  // Busy bit is set at the edge that issues the writer
  assign claim    = accept & dec.writesDest;
  assign claimIdx = dec.destIdx;

  // Taken when cc hits any bit of the opcode mask
  assign branchTaken = dec.isBranch & (|(cc & dec.opcode[2:0]));

  ////////////////////////////////////////////////////////////////////////////
  // Issue register
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge I_CLOCK) begin
    if (!rstN) begin
      issue.valid <= 1'b0;
    end else begin
      issue.valid <= accept;   // Bubble when nothing is taken
      if (accept) begin
        issue.pc          <= dec.pc;
        issue.opcode      <= dec.opcode;
        issue.src1Value   <= src1Value;
        issue.src2Value   <= src2Value;
        issue.destValue   <= dec.isStore ? storeValue : src2Value;
        issue.destIdx     <= dec.destIdx;
        issue.imm         <= dec.imm;
        issue.branchTaken <= branchTaken;
      end
    end
  end

  // A claiming instruction is never stalled and shows up in the next packet
  claimIssues: assert property (@(posedge I_CLOCK) disable iff (!rstN)
    claim |-> (!depStall ##1 (issue.valid && issue.destIdx == $past(claimIdx))))
    else $error("Claim of R%0d without a matching issue", claimIdx);

endmodule

`default_nettype wire

// ==== logic/regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

// Scalar registers, busy scoreboard and condition code
// All reads see the write-back of the current cycle
module regFile (
  input  wire                      I_CLOCK,
  input  wire                      rstN,
  input  wire decodePkg::decoded_t dec,
  input  wire decodePkg::wbPkt_t   wb,
  input  wire                      claim,
  input  wire decodePkg::regIdx_t  claimIdx,
  output decodePkg::word_t         src1Value,
  output decodePkg::word_t         src2Value,
  output decodePkg::word_t         storeValue,
  output logic                     src1Busy,
  output logic                     src2Busy,
  output logic                     anyBusy,
  output decodePkg::cc_t           cc
);

  decodePkg::word_t              regs [decodePkg::numRegs];
  logic [decodePkg::numRegs-1:0] busy;        // Pending write per register
  logic [decodePkg::numRegs-1:0] busyNext;
  logic [decodePkg::numRegs-1:0] wbMask;      // One-hot of the write-back index
  decodePkg::cc_t                ccReg;
  decodePkg::cc_t                wbCc;        // Code of the incoming data
  decodePkg::regIdx_t            src2BusyIdx;

  // N when the sign bit is set, Z on zero, P otherwise
  function automatic decodePkg::cc_t ccOf(input decodePkg::word_t data);
    if (data[$bits(decodePkg::word_t)-1]) begin
      return decodePkg::CC_N;
    end else if (data == '0) begin
      return decodePkg::CC_Z;
    end else begin
      return decodePkg::CC_P;
    end
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Scoreboard next state
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    wbMask = '0;
    if (wb.en) begin
      wbMask[wb.idx] = 1'b1;
    end
  end

  always_comb begin
    busyNext = busy & ~wbMask;         // Write-back retires the claim
    if (claim) begin
      busyNext[claimIdx] = 1'b1;       // New claim wins on the same index
    end
  end

  assign wbCc = ccOf(wb.data);

  always_ff @(posedge I_CLOCK) begin
    if (!rstN) begin
      for (int i = 0; i < decodePkg::numRegs; i++) begin
        regs[i] <= '0;
      end
      busy  <= '0;
      ccReg <= decodePkg::CC_Z;
    end else begin
      if (wb.en) begin
        regs[wb.idx] <= wb.data;
        ccReg        <= wbCc;
      end
      busy <= busyNext;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Forwarded reads
  ////////////////////////////////////////////////////////////////////////////
  assign src1Value  = wbMask[dec.src1Idx] ? wb.data : regs[dec.src1Idx];
  assign src2Value  = wbMask[dec.src2Idx] ? wb.data : regs[dec.src2Idx];
  assign storeValue = wbMask[dec.destIdx] ? wb.data : regs[dec.destIdx];

  // Second operand of STW is its store-data register
  assign src2BusyIdx = dec.isStore ? dec.destIdx : dec.src2Idx;

  assign src1Busy = busy[dec.src1Idx] & ~wbMask[dec.src1Idx];
  assign src2Busy = busy[src2BusyIdx] & ~wbMask[src2BusyIdx];
  assign anyBusy  = |(busy & ~wbMask);     // Branch wait
  assign cc       = wb.en ? wbCc : ccReg;  // Branch sees this cycle's result

  // Every write-back retires an earlier claim
  wbNeedsClaim: assert property (@(posedge I_CLOCK) disable iff (!rstN)
    wb.en |-> busy[wb.idx])
    else $error("Write-back to R%0d with no pending claim", wb.idx);

endmodule

`default_nettype wire
